// ==== hdl/mipsDefs.svh ====
// MIPS core constants
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath width
`define MIPS_WORD 32

// Register file geometry
`define MIPS_REG_ADDR 5
`define MIPS_NUM_REGS 32

// First instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Reaching this PC ends the program
`define MIPS_HALT_ADDR 32'h00000000

// Result register, exposed as register_v0
`define MIPS_V0 2

`endif

// ==== hdl/mipsPkg.sv ====
// MIPS shared types
`include "mipsDefs.svh"

package mipsPkg;

    // Primary opcodes, R-type ops share opcode zero
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // Function codes of the R-type group
    typedef enum logic [5:0] {
        F_SLL  = 6'd0,
        F_SRL  = 6'd2,
        F_SRA  = 6'd3,
        F_JR   = 6'd8,
        F_ADDU = 6'd33,
        F_SUBU = 6'd35,
        F_AND  = 6'd36,
        F_OR   = 6'd37,
        F_XOR  = 6'd38,
        F_SLT  = 6'd42,
        F_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpuState_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`MIPS_REG_ADDR-1:0] rs;
        logic [`MIPS_REG_ADDR-1:0] rt;
        logic [`MIPS_REG_ADDR-1:0] rd;
        logic [4:0]                shamt;
        funct_t                    funct;
    } rType_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`MIPS_REG_ADDR-1:0] rs;
        logic [`MIPS_REG_ADDR-1:0] rt;
        logic [15:0]               imm16;
    } iType_t;

    // Same fetched word, seen as register or immediate format
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_t;

endpackage

// ==== hdl/mipsAlu.sv ====
// MIPS ALU
`include "mipsDefs.svh"

module mipsAlu
    import mipsPkg::*;
(
    input  instrWord_t            instr,
    input  logic [`MIPS_WORD-1:0] rsData,
    input  logic [`MIPS_WORD-1:0] rtData,
    output logic [`MIPS_WORD-1:0] aluResult,
    output logic                  equal
);

    aluOp_t                aluOp;
    logic [`MIPS_WORD-1:0] signImm;
    logic [`MIPS_WORD-1:0] zeroImm;
    logic [`MIPS_WORD-1:0] opB;

    assign signImm = {{(`MIPS_WORD-16){instr.iType.imm16[15]}}, instr.iType.imm16};
    assign zeroImm = {{(`MIPS_WORD-16){1'b0}}, instr.iType.imm16};

    // Operation from the function code for R-type, else from the opcode
    always_comb begin
        aluOp = ALU_ADD;
        if (instr.rType.opcode == OP_R) begin
            case (instr.rType.funct)
                F_SUBU:  aluOp = ALU_SUB;
                F_AND:   aluOp = ALU_AND;
                F_OR:    aluOp = ALU_OR;
                F_XOR:   aluOp = ALU_XOR;
                F_SLT:   aluOp = ALU_SLT;
                F_SLTU:  aluOp = ALU_SLTU;
                F_SLL:   aluOp = ALU_SLL;
                F_SRL:   aluOp = ALU_SRL;
                F_SRA:   aluOp = ALU_SRA;
                default: aluOp = ALU_ADD;
            endcase
        end else begin
            case (instr.iType.opcode)
                OP_SLTI:  aluOp = ALU_SLT;
                OP_SLTIU: aluOp = ALU_SLTU;
                OP_ANDI:  aluOp = ALU_AND;
                OP_ORI:   aluOp = ALU_OR;
                OP_XORI:  aluOp = ALU_XOR;
                OP_LUI:   aluOp = ALU_LUI;
                default:  aluOp = ALU_ADD;
            endcase
        end
    end

    // Logical immediates are zero-extended, the rest sign-extended
    always_comb begin
        case (instr.iType.opcode)
            OP_R:                     opB = rtData;
            OP_ANDI, OP_ORI, OP_XORI: opB = zeroImm;
            default:                  opB = signImm;
        endcase
    end

    always_comb begin
        case (aluOp)
            ALU_SUB:  aluResult = rsData - opB;
            ALU_AND:  aluResult = rsData & opB;
            ALU_OR:   aluResult = rsData | opB;
            ALU_XOR:  aluResult = rsData ^ opB;
            ALU_SLT:  aluResult = {{(`MIPS_WORD-1){1'b0}}, $signed(rsData) < $signed(opB)};
            ALU_SLTU: aluResult = {{(`MIPS_WORD-1){1'b0}}, rsData < opB};
            // Shifts act on rt by shamt
            ALU_SLL:  aluResult = opB << instr.rType.shamt;
            ALU_SRL:  aluResult = opB >> instr.rType.shamt;
            ALU_SRA:  aluResult = $signed(opB) >>> instr.rType.shamt;
            ALU_LUI:  aluResult = {instr.iType.imm16, 16'h0000};
            default:  aluResult = rsData + opB;
        endcase
    end

    // Branch compare
    assign equal = (rsData == rtData);

endmodule

// ==== hdl/mipsRegFile.sv ====
// MIPS register file
`include "mipsDefs.svh"

module mipsRegFile
    import mipsPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`MIPS_REG_ADDR-1:0] rsAddr,
    input  logic [`MIPS_REG_ADDR-1:0] rtAddr,
    input  logic [`MIPS_REG_ADDR-1:0] wrAddr,
    input  logic [`MIPS_WORD-1:0]     wrData,
    input  logic                      wrEn,
    output logic [`MIPS_WORD-1:0]     rsData,
    output logic [`MIPS_WORD-1:0]     rtData,
    output logic [`MIPS_WORD-1:0]     v0
);

    logic [`MIPS_WORD-1:0] regs [`MIPS_NUM_REGS];

    // Register 0 is never written so it reads back as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];
    assign v0     = regs[`MIPS_V0];

endmodule

// ==== hdl/mipsControl.sv ====
// MIPS multicycle control
`include "mipsDefs.svh"

module mipsControl
    import mipsPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      waitrequest,
    input  logic [`MIPS_WORD-1:0]     readdata,
    input  logic [`MIPS_WORD-1:0]     rsData,
    input  logic [`MIPS_WORD-1:0]     rtData,
    input  logic [`MIPS_WORD-1:0]     aluResult,
    input  logic                      equal,
    output logic                      active,
    output logic [`MIPS_WORD-1:0]     address,
    output logic                      read,
    output logic                      write,
    output logic [`MIPS_WORD-1:0]     writedata,
    output logic [`MIPS_WORD/8-1:0]   byteenable,
    output instrWord_t                instr,
    output logic [`MIPS_REG_ADDR-1:0] rsAddr,
    output logic [`MIPS_REG_ADDR-1:0] rtAddr,
    output logic [`MIPS_REG_ADDR-1:0] wrAddr,
    output logic [`MIPS_WORD-1:0]     wrData,
    output logic                      wrEn
);

    cpuState_t             state;
    logic [`MIPS_WORD-1:0] pc;
    logic [`MIPS_WORD-1:0] pcPlus4;
    logic [`MIPS_WORD-1:0] branchTarget;
    logic [`MIPS_WORD-1:0] nextPc;
    opcode_t               opcode;
    funct_t                funct;
    logic                  isLoad;
    logic                  isStore;
    logic                  writesBack;
    logic                  retire;

    assign opcode  = instr.rType.opcode;
    assign funct   = instr.rType.funct;
    assign isLoad  = (opcode == OP_LW);
    assign isStore = (opcode == OP_SW);

    // Instruction done after a non-memory EXEC or an accepted MEM transfer
    assign retire = ((state == EXEC) && !isLoad && !isStore)
                  || ((state == MEM) && !waitrequest);

    always_comb begin
        case (opcode)
            OP_R:     writesBack = (funct != F_JR);
            OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                      writesBack = 1'b1;
            default:  writesBack = 1'b0;
        endcase
    end

    // Next PC without a delay slot
    assign pcPlus4      = pc + `MIPS_WORD'd4;
    assign branchTarget = pcPlus4
                        + {{(`MIPS_WORD-18){instr.iType.imm16[15]}}, instr.iType.imm16, 2'b00};

    always_comb begin
        nextPc = pcPlus4;
        case (opcode)
            OP_R:    if (funct == F_JR) nextPc = rsData;
            OP_J:    nextPc = {pcPlus4[`MIPS_WORD-1 -: 4], instr[25:0], 2'b00};
            OP_BEQ:  if (equal) nextPc = branchTarget;
            OP_BNE:  if (!equal) nextPc = branchTarget;
            default: nextPc = pcPlus4;
        endcase
    end

    // Reset starts in FETCH at the reset vector
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            active <= 1'b1;
            pc     <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                FETCH:   if (!waitrequest) state <= EXEC;
                EXEC:    if (isLoad || isStore) state <= MEM;
                default: state <= state;
            endcase
            if (retire) begin
                pc <= nextPc;
                if (nextPc == `MIPS_HALT_ADDR) begin
                    state  <= HALT;
                    active <= 1'b0;
                end else begin
                    state <= FETCH;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            instr <= readdata;
        end
    end

    // Bus levels held until waitrequest drops and kept low in reset
    assign read       = !reset && ((state == FETCH) || ((state == MEM) && isLoad));
    assign write      = !reset && (state == MEM) && isStore;
    assign address    = (state == MEM) ? aluResult : pc;
    assign writedata  = rtData;
    assign byteenable = '1;

    // Register file access
    assign rsAddr = instr.rType.rs;
    assign rtAddr = instr.rType.rt;
    assign wrAddr = (opcode == OP_R) ? instr.rType.rd : instr.iType.rt;
    assign wrData = (state == MEM) ? readdata : aluResult;
    assign wrEn   = ((state == EXEC) && writesBack)
                  || ((state == MEM) && isLoad && !waitrequest);

endmodule

// ==== hdl/mipsCpuBus.sv ====
// MIPS CPU bus top level
`include "mipsDefs.svh"

module mipsCpuBus
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    output logic                     active,
    output logic [`MIPS_WORD-1:0]    register_v0,
    output logic [`MIPS_WORD-1:0]    address,
    output logic                     write,
    output logic                     read,
    input  logic                     waitrequest,
    output logic [`MIPS_WORD-1:0]    writedata,
    output logic [`MIPS_WORD/8-1:0]  byteenable,
    input  logic [`MIPS_WORD-1:0]    readdata
);

    instrWord_t                instr;
    logic [`MIPS_REG_ADDR-1:0] rsAddr;
    logic [`MIPS_REG_ADDR-1:0] rtAddr;
    logic [`MIPS_REG_ADDR-1:0] wrAddr;
    logic [`MIPS_WORD-1:0]     wrData;
    logic                      wrEn;
    logic [`MIPS_WORD-1:0]     rsData;
    logic [`MIPS_WORD-1:0]     rtData;
    logic [`MIPS_WORD-1:0]     aluResult;
    logic                      equal;

    mipsControl u_control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .rsData(rsData), .rtData(rtData), .aluResult(aluResult), .equal(equal),
        .active(active), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .instr(instr),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn)
    );

    mipsRegFile u_regFile (
        .clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .rsData(rsData), .rtData(rtData), .v0(register_v0)
    );

    mipsAlu u_alu (
        .instr(instr), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .equal(equal)
    );

endmodule

// ==== tests/mipsChecker.sv ====
// MIPS bus and result checker
`include "mipsDefs.svh"

module mipsChecker (
    input  logic        clk,
    input  logic        reset,
    input  logic        active,
    input  logic [31:0] register_v0,
    input  logic [31:0] address,
    input  logic        write,
    input  logic        read,
    input  logic        waitrequest,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    input  int          testIdx,
    input  logic        testEnd,
    input  logic [31:0] expV0,
    input  logic        expStoreEn,
    input  logic [31:0] expStoreAddr,
    input  logic [31:0] expStoreData,
    output int          passCount,
    output int          failCount
);

    int   testErrors;
    int   storeCount;
    logic firstRead;
    logic resetSeen;

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
        testErrors++;
    endtask

    initial begin
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
        storeCount = 0;
        firstRead  = 1'b0;
        resetSeen  = 1'b0;
    end

    // Values taken at the rising edge as the DUT sees them
    always @(posedge clk) begin
        if (reset) begin
            if (resetSeen && active !== 1'b1) reportMismatch("active", 32'd1, 32'(active));
            if (resetSeen && write !== 1'b0) reportMismatch("write", 32'd0, 32'(write));
            if (resetSeen && read !== 1'b0) reportMismatch("read", 32'd0, 32'(read));
            resetSeen  = 1'b1;
            firstRead  = 1'b1;
            storeCount = 0;
        end else begin
            resetSeen = 1'b0;
            // First cycle out of reset fetches from the reset vector
            if (firstRead) begin
                if (read !== 1'b1) reportMismatch("read", 32'd1, 32'(read));
                if (address !== `MIPS_RESET_VECTOR)
                    reportMismatch("address", `MIPS_RESET_VECTOR, address);
                firstRead = 1'b0;
            end
            // Accepted write only
            if (write === 1'b1 && waitrequest === 1'b0) begin
                storeCount++;
                if (!expStoreEn) begin
                    $display("Test %0d: unexpected bus write at time %0t", testIdx, $time);
                    testErrors++;
                end else begin
                    if (address !== expStoreAddr) reportMismatch("address", expStoreAddr, address);
                    if (writedata !== expStoreData)
                        reportMismatch("writedata", expStoreData, writedata);
                    if (byteenable !== 4'hF)
                        reportMismatch("byteenable", 32'hF, 32'(byteenable));
                end
            end
            if (testEnd) begin
                if (register_v0 !== expV0) reportMismatch("register_v0", expV0, register_v0);
                if (expStoreEn && storeCount != 1) begin
                    $display("Test %0d: expected one bus write but saw %0d", testIdx, storeCount);
                    testErrors++;
                end
                if (testErrors == 0) begin
                    $display("Test %0d passed", testIdx);
                    passCount++;
                end else begin
                    $display("Test %0d failed with %0d errors", testIdx, testErrors);
                    failCount++;
                end
                testErrors = 0;
            end
        end
    end

endmodule

// ==== tests/mipsCpuBusTb.sv ====
// MIPS CPU bus testbench
`include "mipsDefs.svh"

module mipsCpuBusTb
    import mipsPkg::*;
;

    localparam int          NUM_TESTS  = 7;
    localparam int          MAX_CYCLES = 4000;
    localparam logic [31:0] JR_ZERO    = 32'h00000008;
    localparam logic [31:0] A          = 32'd100;
    localparam logic [31:0] B          = 32'hFFFFFFF9;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic        active;
    logic        write;
    logic        read;
    logic        testEnd;
    logic        randWait;
    logic [31:0] readdata;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] mem [256];
    logic [31:0] code [$];
    logic [31:0] rngState;
    int          progStart [NUM_TESTS];
    logic        rowRand [NUM_TESTS];
    logic [31:0] rowV0 [NUM_TESTS];
    logic        rowStoreEn [NUM_TESTS];
    logic [31:0] rowStoreAddr [NUM_TESTS];
    logic [31:0] rowStoreData [NUM_TESTS];
    int          testIdx;
    int          passCount;
    int          failCount;
    int          timeouts;
    int          cycles;

    mipsCpuBus u_mipsCpuBus (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    mipsChecker u_checker (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .testIdx(testIdx),
        .testEnd(testEnd), .expV0(rowV0[testIdx]), .expStoreEn(rowStoreEn[testIdx]),
        .expStoreAddr(rowStoreAddr[testIdx]), .expStoreData(rowStoreData[testIdx]),
        .passCount(passCount), .failCount(failCount)
    );

    // Instruction encoders
    function automatic logic [31:0] encR(int rs, int rt, int rd, int sh, funct_t fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] encI(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] encJ(logic [31:0] target);
        return {OP_J, target[27:2]};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic setRow(int t, int start, logic rnd, logic [31:0] v0, logic stEn,
                          logic [31:0] stAddr, logic [31:0] stData);
        progStart[t]    = start;
        rowRand[t]      = rnd;
        rowV0[t]        = v0;
        rowStoreEn[t]   = stEn;
        rowStoreAddr[t] = stAddr;
        rowStoreData[t] = stData;
    endtask

    // Copies one program to the reset vector, up to and including its JR $0
    task automatic loadProgram(int start);
        int i;
        for (i = 0; i < 256; i++) mem[i] = '0;
        i = 0;
        do begin
            mem[i] = code[start + i];
            i++;
        end while (code[start + i - 1] != JR_ZERO);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory model, inputs change on the falling edge
    always @(negedge clk) begin
        if (randWait) begin
            rngState    = xorshift(rngState);
            waitrequest = rngState[0];
        end else begin
            waitrequest = 1'b0;
        end
        readdata = mem[address[9:2]];
    end

    always @(posedge clk) begin
        if (write === 1'b1 && waitrequest === 1'b0) mem[address[9:2]] = writedata;
    end

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        testEnd     = 1'b0;
        randWait    = 1'b0;
        rngState    = 32'd26907;
        testIdx     = 0;
        timeouts    = 0;
        code = '{
            // ALU ops folded into $2 by XOR, starts at 0
            encI(OP_ADDIU, 0, 8, 100), encI(OP_ADDIU, 0, 9, -7), encR(8, 9, 2, 0, F_ADDU),
            encR(8, 9, 10, 0, F_SUBU), encR(2, 10, 2, 0, F_XOR), encR(8, 9, 10, 0, F_AND),
            encR(2, 10, 2, 0, F_XOR), encR(8, 9, 10, 0, F_OR), encR(2, 10, 2, 0, F_XOR),
            encR(8, 9, 10, 0, F_XOR), encR(2, 10, 2, 0, F_XOR), encR(9, 8, 10, 0, F_SLT),
            encR(0, 10, 10, 8, F_SLL), encR(2, 10, 2, 0, F_XOR), encR(8, 9, 10, 0, F_SLTU),
            encR(2, 10, 2, 0, F_XOR), encR(0, 8, 10, 4, F_SLL), encR(2, 10, 2, 0, F_XOR),
            encR(0, 9, 10, 28, F_SRL), encR(2, 10, 2, 0, F_XOR), encR(0, 9, 10, 1, F_SRA),
            encR(2, 10, 2, 0, F_XOR), JR_ZERO,
            // Immediates, starts at 23
            encI(OP_LUI, 0, 8, 16'h1234), encI(OP_ORI, 8, 8, 16'h8765),
            encI(OP_ANDI, 8, 9, 16'hFF0F), encI(OP_XORI, 8, 10, 16'hFFFF),
            encI(OP_SLTIU, 8, 11, -1), encI(OP_SLTI, 8, 12, -1), encI(OP_ADDIU, 0, 13, -1),
            encI(OP_SLTI, 13, 14, 0), encR(0, 14, 14, 4, F_SLL), encR(8, 9, 2, 0, F_XOR),
            encR(2, 10, 2, 0, F_XOR), encR(2, 11, 2, 0, F_XOR), encR(2, 12, 2, 0, F_XOR),
            encR(2, 14, 2, 0, F_XOR), JR_ZERO,
            // Store then load, starts at 38
            encI(OP_LUI, 0, 8, 16'hA5A5), encI(OP_ORI, 8, 8, 16'h1234),
            encI(OP_ADDIU, 0, 9, 16'h00F0), encI(OP_SW, 9, 8, 16), encI(OP_ADDIU, 0, 2, 7),
            encI(OP_LW, 9, 2, 16), JR_ZERO,
            // Branches and jump set marker bits, starts at 45
            encI(OP_ADDIU, 0, 8, 5), encI(OP_ADDIU, 0, 9, 5), encI(OP_ADDIU, 0, 10, 6),
            encI(OP_ADDIU, 0, 2, 0), encI(OP_BEQ, 8, 9, 1), encI(OP_ORI, 2, 2, 16'h01),
            encI(OP_ORI, 2, 2, 16'h02), encI(OP_BEQ, 8, 10, 1), encI(OP_ORI, 2, 2, 16'h04),
            encI(OP_BNE, 8, 10, 1), encI(OP_ORI, 2, 2, 16'h08), encI(OP_BNE, 8, 9, 1),
            encI(OP_ORI, 2, 2, 16'h10), encJ(`MIPS_RESET_VECTOR + 32'd60),
            encI(OP_ORI, 2, 2, 16'h20), encI(OP_ORI, 2, 2, 16'h40), JR_ZERO,
            // Register zero stays zero, starts at 62
            encI(OP_ADDIU, 0, 2, 9), encI(OP_ADDIU, 0, 0, 55), encR(0, 0, 2, 0, F_ADDU),
            JR_ZERO
        };
        setRow(0, 0, 1'b0, (A + B) ^ (A - B) ^ (A & B) ^ (A | B) ^ (A ^ B) ^ 32'h100
               ^ 32'h1 ^ (A << 4) ^ (B >> 28) ^ 32'($signed(B) >>> 1), 1'b0, '0, '0);
        setRow(1, 23, 1'b0, 32'h12348765 ^ 32'h00008705 ^ 32'h1234789A ^ 32'h1 ^ 32'h10,
               1'b0, '0, '0);
        setRow(2, 38, 1'b0, 32'hA5A51234, 1'b1, 32'h100, 32'hA5A51234);
        setRow(3, 45, 1'b0, 32'h56, 1'b0, '0, '0);
        setRow(4, 0, 1'b1, rowV0[0], 1'b0, '0, '0);
        setRow(5, 38, 1'b1, 32'hA5A51234, 1'b1, 32'h100, 32'hA5A51234);
        setRow(6, 62, 1'b1, 32'h0, 1'b0, '0, '0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            reset    = 1'b1;
            testIdx  = t;
            randWait = rowRand[t];
            loadProgram(progStart[t]);
            repeat (2) @(negedge clk);
            reset  = 1'b0;
            cycles = 0;
            while (active !== 1'b0 && cycles < MAX_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (active !== 1'b0) begin
                $display("Timeout: test %0d did not halt within %0d cycles", t, cycles);
                timeouts++;
            end else begin
                testEnd = 1'b1;
                @(negedge clk);
                testEnd = 1'b0;
            end
        end
        @(negedge clk);
        $display("Tests passed: %0d, failed: %0d", passCount, failCount + timeouts);
        if (failCount + timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== mipsCpu.f ====
+incdir+hdl
hdl/mipsPkg.sv
hdl/mipsAlu.sv
hdl/mipsRegFile.sv
hdl/mipsControl.sv
hdl/mipsCpuBus.sv
tests/mipsChecker.sv
tests/mipsCpuBusTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j 0
TOP        ?= mipsCpuBusTb
FILELIST   ?= mipsCpu.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
